// ==== Makefile ====
SRCS := $(wildcard rtl/*.sv bench/*.sv)

all: run

obj_dir/Vtb_lsu: all.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_lsu -f all.f -o Vtb_lsu

run: obj_dir/Vtb_lsu
	./obj_dir/Vtb_lsu > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== all.f ====
rtl/lsu_pkg.sv
rtl/dccm_if.sv
rtl/dccm_mem.sv
rtl/lsu_stbuf.sv
rtl/lsu_dccm_ctl.sv
rtl/lsu_top.sv
bench/tb_clkgen.sv
bench/tb_lsu.sv

// ==== bench/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial clk = 1'b0;
   always #(PERIOD/2) clk = ~clk;    // free running, 50% duty

endmodule

`default_nettype wire

// ==== bench/tb_lsu.sv ====
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

   localparam int DCCM_WORDS  = 64;
   localparam int STBUF_DEPTH = 4;
   localparam int MEM_BYTES   = DCCM_WORDS * BYTES;
   localparam int N_RAND      = 2000;
   // one cycle per request, a held store at most one more, settles and directed tests on top
   localparam int TEST_CYCLES = 2*DCCM_WORDS + 2*N_RAND + 400;
   localparam int CYCLE_LIMIT = TEST_CYCLES + 200;

   logic              clk;
   logic              rst_n;
   logic              req_valid;
   logic              req_store;
   lsu_size_t         req_size;
   logic [ADDR_W-1:0] req_addr;
   logic [DATA_W-1:0] req_wdata;
   logic              ld_valid;
   logic [DATA_W-1:0] ld_data;
   logic              stbuf_full;

   logic [7:0]        ref_mem [MEM_BYTES];    // byte image in program order
   logic [DATA_W-1:0] exp_data_q [$];
   logic [ADDR_W-1:0] exp_addr_q [$];
   int                exp_due_q  [$];         // cycle the load must return in
   int                cyc = 0;
   int                cnt_model;              // store buffer occupancy
   integer            seed = 32'hacb6_1a22;

   tb_clkgen #(.PERIOD(8)) clkgen_inst (.clk);

   lsu_top #(.DCCM_WORDS(DCCM_WORDS), .STBUF_DEPTH(STBUF_DEPTH)) lsu_top_inst (
      .clk, .rst_n, .req_valid, .req_store, .req_size, .req_addr, .req_wdata,
      .ld_valid, .ld_data, .stbuf_full
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_ld_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                                input logic [ADDR_W-1:0] addr);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t: load 0x%h returned 0x%h, expected 0x%h",
                             $time, addr, got, exp));
   endtask

   task automatic check_flag(input logic got, input logic exp, input string name);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                             $time, name, got, exp));
   endtask

   function automatic int size_bytes(input lsu_size_t size);
      case (size)
         SZ_BYTE: return 1;
         SZ_HALF: return 2;
         default: return 4;
      endcase
   endfunction

   // bytes addr .. addr+n-1, little endian, zero extended
   function automatic logic [DATA_W-1:0] ref_load(input logic [ADDR_W-1:0] addr,
                                                  input lsu_size_t size);
      logic [DATA_W-1:0] val;
      val = '0;
      for (int i = 0; i < size_bytes(size); i++) begin
         val[8*i +: 8] = ref_mem[int'(addr) + i];
      end
      return val;
   endfunction

   // occupancy in the next cycle: push adds, an idle port drains the head
   function automatic int cnt_after();
      int n;
      n = cnt_model;
      if (n > 0 && !(req_valid && !req_store)) n = n - 1;
      if (req_valid && req_store) n = n + 1;
      return n;
   endfunction

   function automatic lsu_size_t pick_size(input logic [31:0] r);
      case (int'(r % 3))
         0:       return SZ_BYTE;
         1:       return SZ_HALF;
         default: return SZ_WORD;
      endcase
   endfunction

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) cnt_model <= 0;
      else        cnt_model <= cnt_after();
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT)
         abort_run($sformatf("timeout: run still going after %0d cycles", cyc));
   end

   // mid cycle sampling, dut outputs are settled here
   always @(negedge clk) begin : compare_results
      logic              due;
      logic [DATA_W-1:0] exp_d;
      logic [ADDR_W-1:0] exp_a;
      if (rst_n) begin
         due = (exp_due_q.size() != 0) && (exp_due_q[0] == cyc);
         check_flag(ld_valid, due, "ld_valid");
         check_flag(stbuf_full, cnt_model == STBUF_DEPTH, "stbuf_full");
         if (ld_valid) begin
            exp_d = exp_data_q.pop_front();
            exp_a = exp_addr_q.pop_front();
            void'(exp_due_q.pop_front());
            check_ld_data(ld_data, exp_d, exp_a);
         end
      end
   end

   task automatic drive_idle();
      @(posedge clk);
      req_valid <= 1'b0;
      req_store <= 1'b0;
   endtask

   task automatic issue_load(input logic [ADDR_W-1:0] addr, input lsu_size_t size);
      @(posedge clk);
      req_valid <= 1'b1;
      req_store <= 1'b0;
      req_size  <= size;
      req_addr  <= addr;
      exp_data_q.push_back(ref_load(addr, size));
      exp_addr_q.push_back(addr);
      exp_due_q.push_back(cyc + 3);    // strobe is cyc+1, ld_valid two later
   endtask

   task automatic issue_store(input logic [ADDR_W-1:0] addr, input lsu_size_t size,
                              input logic [DATA_W-1:0] wdata);
      @(negedge clk);
      while (cnt_after() >= STBUF_DEPTH) begin    // hold while buffer would be full
         @(posedge clk);
         req_valid <= 1'b0;
         @(negedge clk);
      end
      @(posedge clk);
      req_valid <= 1'b1;
      req_store <= 1'b1;
      req_size  <= size;
      req_addr  <= addr;
      req_wdata <= wdata;
      for (int i = 0; i < size_bytes(size); i++) begin
         ref_mem[int'(addr) + i] = wdata[8*i +: 8];
      end
   endtask

   // idle until every load returned and the buffer is empty
   task automatic settle();
      drive_idle();
      while (cnt_model != 0 || exp_due_q.size() != 0) @(posedge clk);
   endtask

   initial begin
      logic [31:0]       r;
      logic [31:0]       r2;
      logic [ADDR_W-1:0] a;
      lsu_size_t         sz;
      int                w;
      int                off;
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req_store = 1'b0;
      req_size  = SZ_WORD;
      req_addr  = '0;
      req_wdata = '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_flag(ld_valid, 1'b0, "ld_valid after reset");
      check_flag(stbuf_full, 1'b0, "stbuf_full after reset");

      $display("test 1: fill and read back all words");
      for (w = 0; w < DCCM_WORDS; w++) begin
         a = ADDR_W'(w*4);
         issue_store(a, SZ_WORD, {a ^ 16'h5a3c, ~a});    // pattern over the whole address
      end
      for (w = 0; w < DCCM_WORDS; w++) issue_load(ADDR_W'(w*4), SZ_WORD);
      settle();

      $display("test 2: sub-word stores forwarded to loads");
      for (int k = 0; k < 8; k++) begin
         a = ADDR_W'((3 + 5*k) * 4);
         issue_store(a + 1, SZ_BYTE, $random(seed));
         issue_load(a, SZ_WORD);
         issue_store(a + 2, SZ_HALF, $random(seed));
         issue_store(a + 3, SZ_BYTE, $random(seed));    // overlaps the half
         issue_load(a, SZ_WORD);
         issue_load(a + 2, SZ_HALF);
         issue_store(a, SZ_WORD, $random(seed));
         issue_load(a + 1, SZ_BYTE);
      end
      settle();

      $display("test 3: unaligned loads across a word boundary");
      for (int k = 0; k < 16; k++) begin
         a = ADDR_W'((2 + 3*k) * 4);
         issue_load(a + 3, SZ_HALF);
         issue_load(a + 1, SZ_WORD);
         issue_load(a + 2, SZ_WORD);
         issue_load(a + 3, SZ_WORD);
         issue_store(a + 4, SZ_BYTE, $random(seed));    // lands in the hi word
         issue_load(a + 3, SZ_WORD);
         issue_store(a + 2, SZ_HALF, $random(seed));    // lo word only
         issue_load(a + 2, SZ_WORD);
      end
      settle();

      // a store held behind a burst of loads, forwarded until it drains
      $display("test 4: load burst blocks the drain");
      for (int k = 0; k < 4; k++) begin
         a = ADDR_W'((10 + 7*k) * 4);
         issue_store(a + ADDR_W'(k), SZ_BYTE, $random(seed));
         for (int j = 0; j < 16; j++) begin
            if (j % 4 == 3) issue_load(a, SZ_WORD);
            else            issue_load(a + ADDR_W'(j % 4), SZ_BYTE);
         end
         settle();
         issue_load(a, SZ_WORD);    // now from the dccm itself
         issue_load(a + 1, SZ_HALF);
         settle();
      end

      $display("test 5: random mix of %0d requests", N_RAND);
      for (int n = 0; n < N_RAND; n++) begin
         r  = $random(seed);
         r2 = $random(seed);
         sz = pick_size(r >> 8);
         if (r[2:0] == 3'd0) begin
            drive_idle();    // lets the buffer drain now and then
         end else if (r[2:0] <= 3'd3) begin
            w = int'(r2 % DCCM_WORDS);
            case (sz)
               SZ_BYTE: off = int'(r2[17:16]);
               SZ_HALF: off = 2 * int'(r2[17]);
               default: off = 0;
            endcase
            issue_store(ADDR_W'(w*4 + off), sz, $random(seed));
         end else begin
            a = ADDR_W'(r2 % 32'(MEM_BYTES - size_bytes(sz) + 1));
            issue_load(a, sz);
         end
      end
      settle();

      if (exp_due_q.size() == 0 && cnt_model == 0 && !stbuf_full) begin
         $display("sim passed");
         $finish;
      end else begin
         abort_run("loads or stores still pending at the end of the run");
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dccm_if.sv ====
`default_nettype none

// single write port, lo/hi read pair for unaligned loads
interface dccm_if import lsu_pkg::*; #(
   parameter int IDX_W = 6    // word index width
) ();

   logic              wren;         // store buffer drain
   logic [IDX_W-1:0]  wr_addr;
   logic [DATA_W-1:0] wr_data;      // already in its byte lanes
   logic [BYTES-1:0]  wr_byteen;

   logic              rden;         // dc1 load
   logic [IDX_W-1:0]  rd_addr_lo;   // word of the start address
   logic [IDX_W-1:0]  rd_addr_hi;   // word of the end address
   logic [DATA_W-1:0] rd_data_lo;   // valid in dc2
   logic [DATA_W-1:0] rd_data_hi;

   modport ctl (
      output wren, wr_addr, wr_data, wr_byteen,
      output rden, rd_addr_lo, rd_addr_hi,
      input  rd_data_lo, rd_data_hi
   );

   modport mem (
      input  wren, wr_addr, wr_data, wr_byteen,
      input  rden, rd_addr_lo, rd_addr_hi,
      output rd_data_lo, rd_data_hi
   );

endinterface

`default_nettype wire

// ==== rtl/dccm_mem.sv ====
`default_nettype none

module dccm_mem import lsu_pkg::*; #(
   parameter int DCCM_WORDS = 64
) (
   input logic clk,
   dccm_if.mem mem
);

   logic [DATA_W-1:0] ram [DCCM_WORDS];    // word array, no reset

   // byte lane writes, sub-word stores never touch the other lanes
   always_ff @(posedge clk) begin
      if (mem.wren) begin
         for (int b = 0; b < BYTES; b++) begin
            if (mem.wr_byteen[b]) begin
               ram[mem.wr_addr][8*b +: 8] <= mem.wr_data[8*b +: 8];
            end
         end
      end
   end

   // both read ports flop on rden, data shows up in dc2
   // read and write never share a cycle, so no bypass needed
   always_ff @(posedge clk) begin
      if (mem.rden) begin
         mem.rd_data_lo <= ram[mem.rd_addr_lo];
         mem.rd_data_hi <= ram[mem.rd_addr_hi];    // same word as lo when aligned
      end
   end

endmodule

`default_nettype wire

// ==== rtl/lsu_dccm_ctl.sv ====
`default_nettype none

module lsu_dccm_ctl import lsu_pkg::*; #(
   parameter int DCCM_WORDS = 64
) (
   input  logic               clk,
   input  logic               rst_n,
   input  lsu_pkt_t           pkt_dc1,
   input  logic               head_valid,      // store buffer head
   input  logic [WADDR_W-1:0] head_addr,
   input  logic [DATA_W-1:0]  head_data,
   input  logic [BYTES-1:0]   head_byteen,
   output logic               commit,          // head wins the port
   output logic [WADDR_W-1:0] fwd_addr_lo,     // start word of the dc1 load
   output logic [WADDR_W-1:0] fwd_addr_hi,     // end word of the dc1 load
   input  logic [DATA_W-1:0]  fwd_data_lo,
   input  logic [DATA_W-1:0]  fwd_data_hi,
   input  logic [BYTES-1:0]   fwd_byteen_lo,
   input  logic [BYTES-1:0]   fwd_byteen_hi,
   dccm_if.ctl                dccm,
   output logic               ld_valid,        // dc3
   output logic [DATA_W-1:0]  ld_data          // right justified, zero extended
);

   localparam int IDX_W = $clog2(DCCM_WORDS);

   logic                rden_dc1;
   logic [ADDR_W-1:0]   end_addr_dc1;        // last byte of the load
   logic                valid_dc2;
   logic                valid_dc3;
   logic [OFF_W-1:0]    off_dc2;
   logic [OFF_W-1:0]    off_dc3;
   lsu_size_t           size_dc2;
   lsu_size_t           size_dc3;
   logic [2*DATA_W-1:0] fwd_data_dc2;        // {hi, lo}
   logic [2*DATA_W-1:0] fwd_data_dc3;
   logic [2*BYTES-1:0]  fwd_byteen_dc2;
   logic [2*BYTES-1:0]  fwd_byteen_dc3;
   logic [2*DATA_W-1:0] mem_data_dc3;        // dccm lo/hi pair
   logic [2*DATA_W-1:0] merged_dc3;
   logic [DATA_W-1:0]   shifted_dc3;
   logic [DATA_W-1:0]   size_mask_dc3;
   logic [BYTES-1:0]    size_be_dc3;

   assign rden_dc1 = pkt_dc1.valid & pkt_dc1.load;    // only loads read, no rmw

   always_comb begin
      case (pkt_dc1.size)
         SZ_BYTE: end_addr_dc1 = pkt_dc1.addr;
         SZ_HALF: end_addr_dc1 = pkt_dc1.addr + ADDR_W'(1);
         default: end_addr_dc1 = pkt_dc1.addr + ADDR_W'(3);
      endcase
   end

   assign fwd_addr_lo = pkt_dc1.addr[ADDR_W-1:OFF_W];
   assign fwd_addr_hi = end_addr_dc1[ADDR_W-1:OFF_W];

   // single port, the drain loses to any dc1 load
   assign commit = head_valid & ~rden_dc1;

   assign dccm.wren       = commit;
   assign dccm.wr_addr    = head_addr[IDX_W-1:0];
   assign dccm.wr_data    = head_data;
   assign dccm.wr_byteen  = head_byteen;
   assign dccm.rden       = rden_dc1;
   assign dccm.rd_addr_lo = fwd_addr_lo[IDX_W-1:0];
   assign dccm.rd_addr_hi = fwd_addr_hi[IDX_W-1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_dc2 <= 1'b0;
         valid_dc3 <= 1'b0;
      end else begin
         valid_dc2 <= rden_dc1;
         valid_dc3 <= valid_dc2;
      end
   end

   // forwarded bytes are a dc1 snapshot, same cycle the dccm is read
   always_ff @(posedge clk) begin
      if (rden_dc1) begin
         off_dc2        <= pkt_dc1.addr[OFF_W-1:0];
         size_dc2       <= pkt_dc1.size;
         fwd_data_dc2   <= {fwd_data_hi, fwd_data_lo};
         fwd_byteen_dc2 <= {fwd_byteen_hi, fwd_byteen_lo};
      end
      if (valid_dc2) begin
         off_dc3        <= off_dc2;
         size_dc3       <= size_dc2;
         fwd_data_dc3   <= fwd_data_dc2;
         fwd_byteen_dc3 <= fwd_byteen_dc2;
         mem_data_dc3   <= {dccm.rd_data_hi, dccm.rd_data_lo};    // memory output of dc2
      end
   end

   // per byte, the store buffer copy wins over the dccm copy
   always_comb begin
      for (int i = 0; i < 2*BYTES; i++) begin
         merged_dc3[8*i +: 8] = fwd_byteen_dc3[i] ? fwd_data_dc3[8*i +: 8] :
                                                    mem_data_dc3[8*i +: 8];
      end
   end

   assign shifted_dc3 = DATA_W'(merged_dc3 >> {off_dc3, 3'b000});    // right justify
   assign size_be_dc3 = size_byteen(size_dc3);

   always_comb begin
      for (int b = 0; b < BYTES; b++) begin
         size_mask_dc3[8*b +: 8] = {8{size_be_dc3[b]}};
      end
   end

   assign ld_valid = valid_dc3;
   assign ld_data  = shifted_dc3 & size_mask_dc3;    // zero extend byte/half

   a_port_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(dccm.wren && dccm.rden))
      else $error("dccm read and write in same cycle");

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   localparam int ADDR_W  = 16;               // byte address width
   localparam int DATA_W  = 32;               // dccm word
   localparam int BYTES   = 4;                // bytes per word
   localparam int OFF_W   = $clog2(BYTES);    // byte offset inside a word
   localparam int WADDR_W = ADDR_W - OFF_W;   // word address, full range

   // access size as carried in the request
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_t;

   // one request, valid only in its strobe cycle
   typedef struct packed {
      logic              valid;
      logic              load;
      logic              store;
      lsu_size_t         size;
      logic [ADDR_W-1:0] addr;    // byte address, loads may be unaligned
   } lsu_pkt_t;

   // right justified byte mask for a size, shift by the offset to place it
   function automatic logic [BYTES-1:0] size_byteen(input lsu_size_t sz);
      logic [BYTES-1:0] be;
      case (sz)
         SZ_BYTE: be = 4'b0001;
         SZ_HALF: be = 4'b0011;
         default: be = 4'b1111;    // word
      endcase
      return be;
   endfunction

endpackage

`default_nettype wire

// ==== rtl/lsu_stbuf.sv ====
`default_nettype none

module lsu_stbuf import lsu_pkg::*; #(
   parameter int STBUF_DEPTH = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               push,           // store strobe
   input  logic [ADDR_W-1:0]  push_addr,
   input  logic [DATA_W-1:0]  push_data,      // right justified store data
   input  lsu_size_t          push_size,
   output logic               full,
   output logic               head_valid,     // oldest entry waiting to drain
   output logic [WADDR_W-1:0] head_addr,
   output logic [DATA_W-1:0]  head_data,
   output logic [BYTES-1:0]   head_byteen,
   input  logic               commit,         // head written to dccm this cycle
   input  logic [WADDR_W-1:0] fwd_addr_lo,    // dc1 load words
   input  logic [WADDR_W-1:0] fwd_addr_hi,
   output logic [DATA_W-1:0]  fwd_data_lo,
   output logic [DATA_W-1:0]  fwd_data_hi,
   output logic [BYTES-1:0]   fwd_byteen_lo,
   output logic [BYTES-1:0]   fwd_byteen_hi
);

   localparam int PTR_W = (STBUF_DEPTH > 1) ? $clog2(STBUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(STBUF_DEPTH + 1);

   logic [WADDR_W-1:0] addr_q   [STBUF_DEPTH];    // word address per entry
   logic [DATA_W-1:0]  data_q   [STBUF_DEPTH];    // data in byte lanes
   logic [BYTES-1:0]   byteen_q [STBUF_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;                     // occupied entries
   logic [OFF_W-1:0]   push_off;
   logic               push_aligned;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(STBUF_DEPTH - 1)) ? '0 : p + 1'b1;    // wrap for any depth
   endfunction

   // walk oldest to youngest, later matches overwrite earlier bytes
   function automatic logic [BYTES+DATA_W-1:0] fwd_word(input logic [WADDR_W-1:0] waddr);
      logic [DATA_W-1:0] d;
      logic [BYTES-1:0]  be;
      int                idx;
      d   = '0;
      be  = '0;
      idx = int'(rd_ptr);
      for (int k = 0; k < STBUF_DEPTH; k++) begin
         if ((k < int'(count)) && (addr_q[idx] == waddr)) begin
            for (int b = 0; b < BYTES; b++) begin
               if (byteen_q[idx][b]) begin
                  d[8*b +: 8] = data_q[idx][8*b +: 8];
                  be[b]       = 1'b1;
               end
            end
         end
         idx = (idx == STBUF_DEPTH - 1) ? 0 : idx + 1;
      end
      return {be, d};
   endfunction

   assign push_off = push_addr[OFF_W-1:0];

   always_ff @(posedge clk) begin
      if (push) begin
         addr_q[wr_ptr]   <= push_addr[ADDR_W-1:OFF_W];
         data_q[wr_ptr]   <= push_data << {push_off, 3'b000};      // move into its lanes
         byteen_q[wr_ptr] <= size_byteen(push_size) << push_off;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (commit) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({push, commit})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // both or neither
         endcase
      end
   end

   assign full        = (count == CNT_W'(STBUF_DEPTH));
   assign head_valid  = (count != '0);
   assign head_addr   = addr_q[rd_ptr];
   assign head_data   = data_q[rd_ptr];
   assign head_byteen = byteen_q[rd_ptr];

   always_comb begin
      {fwd_byteen_lo, fwd_data_lo} = fwd_word(fwd_addr_lo);
      {fwd_byteen_hi, fwd_data_hi} = fwd_word(fwd_addr_hi);
   end

   // stores are naturally aligned, so one entry never spans two words
   always_comb begin
      case (push_size)
         SZ_BYTE: push_aligned = 1'b1;
         SZ_HALF: push_aligned = ~push_off[0];
         SZ_WORD: push_aligned = (push_off == '0);
         default: push_aligned = 1'b0;    // no such size
      endcase
   end

   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
      else $error("store pushed while store buffer full");

   a_no_commit_empty: assert property (@(posedge clk) disable iff (!rst_n)
      commit |-> head_valid)
      else $error("commit with empty store buffer");

   a_push_aligned: assert property (@(posedge clk) disable iff (!rst_n) push |-> push_aligned)
      else $error("misaligned store pushed");

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`default_nettype none

module lsu_top import lsu_pkg::*; #(
   parameter int DCCM_WORDS  = 64,
   parameter int STBUF_DEPTH = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req_valid,     // one cycle strobe
   input  logic              req_store,     // else load
   input  lsu_size_t         req_size,
   input  logic [ADDR_W-1:0] req_addr,
   input  logic [DATA_W-1:0] req_wdata,     // right justified
   output logic              ld_valid,
   output logic [DATA_W-1:0] ld_data,
   output logic              stbuf_full     // source holds stores while high
);

   localparam int IDX_W = $clog2(DCCM_WORDS);

   lsu_pkt_t           pkt_dc1;
   logic               push;
   logic               head_valid;
   logic [WADDR_W-1:0] head_addr;
   logic [DATA_W-1:0]  head_data;
   logic [BYTES-1:0]   head_byteen;
   logic               commit;
   logic [WADDR_W-1:0] fwd_addr_lo;
   logic [WADDR_W-1:0] fwd_addr_hi;
   logic [DATA_W-1:0]  fwd_data_lo;
   logic [DATA_W-1:0]  fwd_data_hi;
   logic [BYTES-1:0]   fwd_byteen_lo;
   logic [BYTES-1:0]   fwd_byteen_hi;

   dccm_if #(.IDX_W(IDX_W)) dccm_bus ();

   // request strobe cycle is dc1
   assign pkt_dc1.valid = req_valid;
   assign pkt_dc1.load  = req_valid & ~req_store;
   assign pkt_dc1.store = req_valid & req_store;
   assign pkt_dc1.size  = req_size;
   assign pkt_dc1.addr  = req_addr;

   assign push = pkt_dc1.store;    // stores go straight to the buffer

   lsu_stbuf #(.STBUF_DEPTH(STBUF_DEPTH)) stbuf_inst (
      .clk, .rst_n, .push,
      .push_addr(req_addr), .push_data(req_wdata), .push_size(req_size),
      .full(stbuf_full),
      .head_valid, .head_addr, .head_data, .head_byteen, .commit,
      .fwd_addr_lo, .fwd_addr_hi,
      .fwd_data_lo, .fwd_data_hi, .fwd_byteen_lo, .fwd_byteen_hi
   );

   lsu_dccm_ctl #(.DCCM_WORDS(DCCM_WORDS)) dccm_ctl_inst (
      .clk, .rst_n, .pkt_dc1,
      .head_valid, .head_addr, .head_data, .head_byteen, .commit,
      .fwd_addr_lo, .fwd_addr_hi,
      .fwd_data_lo, .fwd_data_hi, .fwd_byteen_lo, .fwd_byteen_hi,
      .dccm(dccm_bus.ctl),
      .ld_valid, .ld_data
   );

   dccm_mem #(.DCCM_WORDS(DCCM_WORDS)) dccm_mem_inst (
      .clk,
      .mem(dccm_bus.mem)
   );

endmodule

`default_nettype wire
